// File: Makefile
# Verilator simulation of the level-0 instruction cache

VERILATOR ?= verilator
TOP       ?= tb_l0_icache
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
rtl/l0_cache_pkg.sv
rtl/l0_refill_pkg.sv
rtl/l0_line_store.sv
rtl/l0_refill_ctrl.sv
rtl/l0_prefetch_gen.sv
rtl/l0_icache.sv
+incdir+tests
tests/l0_icache_checker.sv
tests/tb_l0_icache.sv

// File: rtl/l0_cache_pkg.sv
/*
  Geometry of the level-0 instruction cache and its address types.
  Fully associative, LINE_COUNT must be a power of two for the round-robin pointer.
  Fetch words are naturally aligned, so the low FETCH_ALIGN address bits are ignored.
*/
package l0_cache_pkg;

  // Fetch port
  localparam int unsigned FETCH_AW    = 32;
  localparam int unsigned FETCH_DW    = 32;
  localparam int unsigned FETCH_ALIGN = 2;

  // Line geometry
  localparam int unsigned LINE_WIDTH = 128;
  localparam int unsigned LINE_ALIGN = 4;
  localparam int unsigned LINE_COUNT = 4;
  localparam int unsigned TAG_WIDTH  = FETCH_AW - LINE_ALIGN;

  typedef logic [FETCH_AW-1:0]           addr_t;
  typedef logic [FETCH_DW-1:0]           fetch_data_t;
  typedef logic [TAG_WIDTH-1:0]          line_tag_t;

  // One bit per line, used both one-hot and as a strobe
  typedef logic [LINE_COUNT-1:0]         line_sel_t;
  typedef logic [$clog2(LINE_COUNT)-1:0] rr_ptr_t;

endpackage

// File: rtl/l0_icache.sv
/*
  Level-0 instruction cache for one fetch port.
  Hits return data in the same cycle; a miss stalls until one cycle after its refill.
  The core must hold fetch valid and address until the transfer.
*/
`timescale 1ns/1ps

module l0_icache (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       prefetch_en_i,
  input  l0_cache_pkg::addr_t        fetch_addr_i,
  input  logic                       fetch_valid_i,
  output l0_cache_pkg::fetch_data_t  fetch_data_o,
  output logic                       fetch_ready_o,
  output l0_cache_pkg::addr_t        refill_req_addr_o,
  output l0_refill_pkg::refill_id_t  refill_req_id_o,
  output logic                       refill_req_valid_o,
  input  logic                       refill_req_ready_i,
  input  l0_refill_pkg::line_data_t  refill_rsp_data_i,
  input  logic                       refill_rsp_valid_i
);
  import l0_cache_pkg::*;

  line_sel_t hit, prefetch_hit;
  line_sel_t evict_strb, fill_strb, flush_strb;
  line_tag_t evict_tag;
  addr_t     prefetch_addr, prefetch_req_addr;
  logic      prefetch_latch, prefetch_req_valid, prefetch_ready;
  logic      refill_idle;

  l0_line_store i_line_store (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fetch_addr_i    (fetch_addr_i),
    .prefetch_addr_i (prefetch_addr),
    .evict_strb_i    (evict_strb),
    .evict_tag_i     (evict_tag),
    .fill_strb_i     (fill_strb),
    .flush_strb_i    (flush_strb),
    .fill_data_i     (refill_rsp_data_i),
    .hit_o           (hit),
    .prefetch_hit_o  (prefetch_hit),
    .fetch_data_o    (fetch_data_o)
  );

  l0_refill_ctrl i_refill_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_i              (flush_i),
    .fetch_addr_i         (fetch_addr_i),
    .fetch_valid_i        (fetch_valid_i),
    .hit_i                (hit),
    .prefetch_hit_i       (prefetch_hit),
    .prefetch_latch_i     (prefetch_latch),
    .prefetch_addr_i      (prefetch_addr),
    .prefetch_req_valid_i (prefetch_req_valid),
    .prefetch_req_addr_i  (prefetch_req_addr),
    .refill_req_ready_i   (refill_req_ready_i),
    .refill_rsp_valid_i   (refill_rsp_valid_i),
    .fetch_ready_o        (fetch_ready_o),
    .evict_strb_o         (evict_strb),
    .evict_tag_o          (evict_tag),
    .fill_strb_o          (fill_strb),
    .flush_strb_o         (flush_strb),
    .prefetch_ready_o     (prefetch_ready),
    .refill_idle_o        (refill_idle),
    .refill_req_addr_o    (refill_req_addr_o),
    .refill_req_id_o      (refill_req_id_o),
    .refill_req_valid_o   (refill_req_valid_o)
  );

  l0_prefetch_gen i_prefetch_gen (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .prefetch_en_i        (prefetch_en_i),
    .fetch_addr_i         (fetch_addr_i),
    .fetch_valid_i        (fetch_valid_i),
    .hit_i                (hit),
    .prefetch_hit_i       (prefetch_hit),
    .refill_idle_i        (refill_idle),
    .prefetch_ready_i     (prefetch_ready),
    .prefetch_addr_o      (prefetch_addr),
    .prefetch_latch_o     (prefetch_latch),
    .prefetch_req_valid_o (prefetch_req_valid),
    .prefetch_req_addr_o  (prefetch_req_addr)
  );

endmodule

// File: rtl/l0_line_store.sv
/*
  Tag, valid and data registers of all cache lines.
  Lookups are combinational for both the fetch and the prefetch address.
  Strobes take effect on the next clock edge; flush wins over a fill.
*/
`timescale 1ns/1ps

module l0_line_store (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  l0_cache_pkg::addr_t      fetch_addr_i,
  input  l0_cache_pkg::addr_t      prefetch_addr_i,
  input  l0_cache_pkg::line_sel_t  evict_strb_i,
  input  l0_cache_pkg::line_tag_t  evict_tag_i,
  input  l0_cache_pkg::line_sel_t  fill_strb_i,
  input  l0_cache_pkg::line_sel_t  flush_strb_i,
  input  l0_refill_pkg::line_data_t fill_data_i,
  output l0_cache_pkg::line_sel_t  hit_o,
  output l0_cache_pkg::line_sel_t  prefetch_hit_o,
  output l0_cache_pkg::fetch_data_t fetch_data_o
);
  import l0_cache_pkg::*;
  import l0_refill_pkg::*;

  line_tag_t  tag_q [LINE_COUNT];
  line_data_t data_q [LINE_COUNT];
  line_sel_t  valid_q;

  line_tag_t  fetch_tag;
  line_tag_t  prefetch_tag;
  line_data_t hit_line;

  logic [LINE_ALIGN-FETCH_ALIGN-1:0] word_idx;

  assign fetch_tag    = fetch_addr_i[FETCH_AW-1:LINE_ALIGN];
  assign prefetch_tag = prefetch_addr_i[FETCH_AW-1:LINE_ALIGN];
  assign word_idx     = fetch_addr_i[LINE_ALIGN-1:FETCH_ALIGN];

  // --------------------
  // Line registers
  // --------------------

  // Eviction invalidates the line until its fill arrives
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= (valid_q | fill_strb_i) & ~evict_strb_i & ~flush_strb_i;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < LINE_COUNT; i++) begin
      if (evict_strb_i[i]) begin
        tag_q[i] <= evict_tag_i;
      end
      if (fill_strb_i[i]) begin
        data_q[i] <= fill_data_i;
      end
    end
  end

  // --------------------
  // Tag compare
  // --------------------
  always_comb begin
    for (int i = 0; i < LINE_COUNT; i++) begin
      hit_o[i]          = valid_q[i] && (tag_q[i] == fetch_tag);
      prefetch_hit_o[i] = valid_q[i] && (tag_q[i] == prefetch_tag);
    end
  end

  // --------------------
  // Word select
  // --------------------

  // At most one line hits, so an OR over the masked lines is enough
  always_comb begin
    hit_line = '0;
    for (int i = 0; i < LINE_COUNT; i++) begin
      if (hit_o[i]) begin
        hit_line = hit_line | data_q[i];
      end
    end
  end

  assign fetch_data_o = hit_line[word_idx*FETCH_DW +: FETCH_DW];

endmodule

// File: rtl/l0_prefetch_gen.sv
/*
  Next-line prefetcher. A candidate is the line after the current fetch line.
  Only one prefetch is held at a time; it waits for the controller to accept it.
*/
`timescale 1ns/1ps

module l0_prefetch_gen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     prefetch_en_i,
  input  l0_cache_pkg::addr_t      fetch_addr_i,
  input  logic                     fetch_valid_i,
  input  l0_cache_pkg::line_sel_t  hit_i,
  input  l0_cache_pkg::line_sel_t  prefetch_hit_i,
  input  logic                     refill_idle_i,
  input  logic                     prefetch_ready_i,
  output l0_cache_pkg::addr_t      prefetch_addr_o,
  output logic                     prefetch_latch_o,
  output logic                     prefetch_req_valid_o,
  output l0_cache_pkg::addr_t      prefetch_req_addr_o
);
  import l0_cache_pkg::*;

  logic  candidate;
  logic  req_valid_q;
  addr_t req_addr_q;

  // Line-aligned address of the following line
  assign prefetch_addr_o = {fetch_addr_i[FETCH_AW-1:LINE_ALIGN] + line_tag_t'(1),
                            {LINE_ALIGN{1'b0}}};

  assign candidate = prefetch_en_i && fetch_valid_i && (hit_i != '0)
                     && (prefetch_hit_i == '0) && refill_idle_i;
  assign prefetch_latch_o = candidate && !req_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (prefetch_latch_o) begin
      req_valid_q <= 1'b1;
    end else if (prefetch_ready_i) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (prefetch_latch_o) begin
      req_addr_q <= prefetch_addr_o;
    end
  end

  assign prefetch_req_valid_o = req_valid_q;
  assign prefetch_req_addr_o  = req_addr_q;

endmodule

// File: rtl/l0_refill_ctrl.sv
/*
  Miss handling for the level-0 cache with a single pending refill.
  A demand miss always wins the request port over a held prefetch.
  Responses are taken in order and always accepted.
*/
`timescale 1ns/1ps

module l0_refill_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  l0_cache_pkg::addr_t        fetch_addr_i,
  input  logic                       fetch_valid_i,
  input  l0_cache_pkg::line_sel_t    hit_i,
  input  l0_cache_pkg::line_sel_t    prefetch_hit_i,
  input  logic                       prefetch_latch_i,
  input  l0_cache_pkg::addr_t        prefetch_addr_i,
  input  logic                       prefetch_req_valid_i,
  input  l0_cache_pkg::addr_t        prefetch_req_addr_i,
  input  logic                       refill_req_ready_i,
  input  logic                       refill_rsp_valid_i,
  output logic                       fetch_ready_o,
  output l0_cache_pkg::line_sel_t    evict_strb_o,
  output l0_cache_pkg::line_tag_t    evict_tag_o,
  output l0_cache_pkg::line_sel_t    fill_strb_o,
  output l0_cache_pkg::line_sel_t    flush_strb_o,
  output logic                       prefetch_ready_o,
  output logic                       refill_idle_o,
  output l0_cache_pkg::addr_t        refill_req_addr_o,
  output l0_refill_pkg::refill_id_t  refill_req_id_o,
  output logic                       refill_req_valid_o
);
  import l0_cache_pkg::*;
  import l0_refill_pkg::*;

  refill_state_e state_q, state_d;
  rr_ptr_t       rr_q, rr_d;
  line_sel_t     keep_strb;
  line_sel_t     pending_line_q;
  logic          miss, miss_q;
  logic          evict_miss, evict_prefetch, evict_req;
  logic          demand_ready;

  assign refill_idle_o = (state_q == REFILL_IDLE);
  assign miss          = fetch_valid_i && (hit_i == '0) && refill_idle_o;
  assign fetch_ready_o = fetch_valid_i && (hit_i != '0);
  assign flush_strb_o  = {LINE_COUNT{flush_i}};

  // A miss stays high under back-pressure, evict only on its first cycle
  assign evict_miss     = miss && !miss_q;
  assign evict_prefetch = prefetch_latch_i;
  assign evict_req      = evict_miss || evict_prefetch;
  assign evict_tag_o    = evict_prefetch ? prefetch_addr_i[FETCH_AW-1:LINE_ALIGN]
                                         : fetch_addr_i[FETCH_AW-1:LINE_ALIGN];

  // --------------------
  // Evictor
  // --------------------

  // Never pick the line in use by the fetch or the one holding the next line
  assign keep_strb = hit_i | prefetch_hit_i;

  always_comb begin
    evict_strb_o = '0;
    rr_d         = rr_q;
    if (evict_req) begin
      evict_strb_o = line_sel_t'(1) << rr_q;
      rr_d         = rr_q + rr_ptr_t'(1);
      if ((evict_strb_o & keep_strb) != '0) begin
        evict_strb_o = line_sel_t'(1) << rr_d;
        rr_d         = rr_q + rr_ptr_t'(2);
      end
    end
  end

  // Victim of the outstanding refill
  always_ff @(posedge clk_i) begin
    if (evict_req) begin
      pending_line_q <= evict_strb_o;
    end
  end

  assign fill_strb_o = refill_rsp_valid_i ? pending_line_q : '0;

  // --------------------
  // Request arbitration
  // --------------------
  always_comb begin
    refill_req_addr_o  = prefetch_req_addr_i;
    refill_req_id_o    = ID_PREFETCH;
    refill_req_valid_o = prefetch_req_valid_i;
    prefetch_ready_o   = refill_req_ready_i;
    demand_ready       = 1'b0;
    if (miss) begin
      refill_req_addr_o  = {fetch_addr_i[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
      refill_req_id_o    = ID_DEMAND;
      refill_req_valid_o = 1'b1;
      prefetch_ready_o   = 1'b0;
      demand_ready       = refill_req_ready_i;
    end
  end

  // --------------------
  // Pending refill FSM
  // --------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      REFILL_IDLE: begin
        // A latched prefetch counts as pending right away
        if ((miss && demand_ready) || prefetch_latch_i) begin
          state_d = REFILL_WAIT;
        end
      end
      REFILL_WAIT: begin
        if (refill_rsp_valid_i) begin
          state_d = REFILL_IDLE;
        end
      end
      default: begin
        state_d = REFILL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= REFILL_IDLE;
      rr_q    <= '0;
      miss_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      rr_q    <= rr_d;
      miss_q  <= miss;
    end
  end

endmodule

// File: rtl/l0_refill_pkg.sv
/*
  Types of the refill port. One refill is outstanding at a time and the
  response carries no id, so the id only tells memory whether it is a prefetch.
*/
package l0_refill_pkg;

  typedef logic [l0_cache_pkg::LINE_WIDTH-1:0] line_data_t;
  typedef logic [0:0]                          refill_id_t;

  localparam refill_id_t ID_DEMAND   = 1'b0;
  localparam refill_id_t ID_PREFETCH = 1'b1;

  // Tracks the single pending refill
  typedef enum logic {
    REFILL_IDLE,
    REFILL_WAIT
  } refill_state_e;

endpackage

// File: tests/tb_mem_pattern.svh
/*
  Memory contents seen by the cache. Every word is its word address XOR a constant,
  so any wrong word or wrong line shows up as a mismatch.
  Included inside the body of each module that needs the pattern.
*/
function automatic logic [31:0] mem_word(input logic [31:0] word_addr);
  return word_addr ^ 32'h5A3C_96E1;
endfunction

// File: tests/l0_icache_checker.sv
/*
  Concurrent checks on the ports of l0_icache, bound into every instance.
  Failures are counted in fail_count for the testbench summary.
*/
`timescale 1ns/1ps

module l0_icache_checker (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      prefetch_en_i,
  input l0_cache_pkg::addr_t       fetch_addr_i,
  input logic                      fetch_valid_i,
  input l0_cache_pkg::fetch_data_t fetch_data_o,
  input logic                      fetch_ready_o,
  input l0_cache_pkg::addr_t       refill_req_addr_o,
  input l0_refill_pkg::refill_id_t refill_req_id_o,
  input logic                      refill_req_valid_o,
  input logic                      refill_req_ready_i
);
  import l0_refill_pkg::*;
  `include "tb_mem_pattern.svh"

  int unsigned fail_count = 0;
  logic        prefetch_seen;

  // Set once prefetching has ever been enabled since reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prefetch_seen <= 1'b0;
    end else if (prefetch_en_i) begin
      prefetch_seen <= 1'b1;
    end
  end

  data_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && fetch_ready_o |-> fetch_data_o == mem_word({2'b00, fetch_addr_i[31:2]}))
    else begin
      fail_count++;
      $error("FAILED fetch_data_o %h expected %h", fetch_data_o,
             mem_word({2'b00, fetch_addr_i[31:2]}));
    end

  // Lines are 16 bytes, so a demand request clears the low four address bits
  demand_addr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_req_valid_o && refill_req_id_o == ID_DEMAND |->
      fetch_valid_i && refill_req_addr_o == (fetch_addr_i & 32'hFFFF_FFF0))
    else begin
      fail_count++;
      $error("FAILED refill_req_addr_o %h fetch_addr_i %h", refill_req_addr_o, fetch_addr_i);
    end

  // Request must hold under back-pressure
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_req_valid_o && !refill_req_ready_i |=>
      refill_req_valid_o && $stable(refill_req_addr_o) && $stable(refill_req_id_o))
    else begin
      fail_count++;
      $error("FAILED refill_req_addr_o %h refill_req_id_o %h changed before ready",
             refill_req_addr_o, refill_req_id_o);
    end

  no_prefetch_when_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !prefetch_seen && !prefetch_en_i |-> !(refill_req_valid_o && refill_req_id_o == ID_PREFETCH))
    else begin
      fail_count++;
      $error("FAILED refill_req_id_o %h with prefetching disabled", refill_req_id_o);
    end

endmodule

bind l0_icache l0_icache_checker i_checker (.*);

// File: tests/tb_l0_icache.sv
/*
  Testbench for l0_icache. Checks live in the bound checker and in a few
  immediate assertions here; a memory responder answers every refill request.
*/
`timescale 1ns/1ps

module tb_l0_icache;
  import l0_cache_pkg::*;
  import l0_refill_pkg::*;
  `include "tb_mem_pattern.svh"

  localparam int WAIT_LIMIT = 300;

  logic clk_i, rst_ni, flush_i, prefetch_en_i, fetch_valid_i, fetch_ready_o;
  logic refill_req_valid_o, refill_req_ready_i, refill_rsp_valid_i;
  addr_t       fetch_addr_i, refill_req_addr_o, rsp_addr;
  fetch_data_t fetch_data_o;
  refill_id_t  refill_req_id_o;
  line_data_t  refill_rsp_data_i, rsp_line;
  logic [15:0] stim_lfsr, rsp_lfsr;
  logic        rsp_pending, seen;
  int          rsp_delay, errors, timeouts, cnt;

  l0_icache dut (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int stim_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = (v << 1) | int'(stim_lfsr[0]);
    end
    return v;
  endfunction

  // ----------------------
  // Memory responder
  // ----------------------
  always @(posedge clk_i) begin
    refill_rsp_valid_i <= 1'b0;
    rsp_lfsr = lfsr_step(rsp_lfsr);
    refill_req_ready_i <= rsp_lfsr[0];
    if (refill_req_valid_o && refill_req_ready_i) begin
      rsp_pending = 1'b1;
      rsp_addr    = refill_req_addr_o;
      rsp_lfsr    = lfsr_step(rsp_lfsr);
      rsp_delay   = int'(rsp_lfsr[0]);
      rsp_lfsr    = lfsr_step(rsp_lfsr);
      rsp_delay   = (rsp_delay << 1) | int'(rsp_lfsr[0]);
    end else if (rsp_pending) begin
      if (rsp_delay == 0) begin
        for (int k = 0; k < 4; k++) begin
          rsp_line[k*32 +: 32] = mem_word({2'b00, rsp_addr[31:2]} + 32'(k));
        end
        refill_rsp_data_i  <= rsp_line;
        refill_rsp_valid_i <= 1'b1;
        rsp_pending = 1'b0;
      end else begin
        rsp_delay--;
      end
    end
  end

  // Holds one fetch until it transfers and notes any demand request on the way
  task automatic fetch_word(input addr_t a, output logic saw_demand);
    int n;
    saw_demand = 1'b0;
    @(posedge clk_i);
    fetch_valid_i <= 1'b1;
    fetch_addr_i  <= a;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge clk_i);
      if (refill_req_valid_o && refill_req_id_o == ID_DEMAND) saw_demand = 1'b1;
      if (fetch_ready_o) break;
    end
    if (n == WAIT_LIMIT) begin
      timeouts++;
      $display("Fetch of address %h never completed", a);
    end
    fetch_valid_i <= 1'b0;
  endtask

  task automatic random_fetches(input int count);
    logic d;
    for (int i = 0; i < count; i++) begin
      fetch_word(32'h1000 + 32'(stim_bits(3) * 16) + 32'(stim_bits(2) * 4), d);
    end
  endtask

  initial begin
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    flush_i            = 1'b0;
    prefetch_en_i      = 1'b0;
    fetch_valid_i      = 1'b0;
    fetch_addr_i       = '0;
    refill_req_ready_i = 1'b0;
    refill_rsp_valid_i = 1'b0;
    refill_rsp_data_i  = '0;
    stim_lfsr          = 16'd33;
    rsp_lfsr           = 16'd33;
    rsp_pending        = 1'b0;
    rsp_delay          = 0;
    errors             = 0;
    timeouts           = 0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    random_fetches(40);

    // Five distinct lines push the first one out of four entries
    for (int i = 0; i < 5; i++) fetch_word(32'h8000 + 32'(i * 256), seen);
    fetch_word(32'h8004, seen);
    assert (seen) else begin
      errors++;
      $display("Refetch of evicted line 8000 caused no demand request");
    end

    fetch_word(32'h8008, seen);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    fetch_word(32'h8008, seen);
    assert (seen) else begin
      errors++;
      $display("Fetch after flush caused no demand request");
    end

    // Next-line prefetch after a hit on 9000
    prefetch_en_i <= 1'b1;
    fetch_word(32'h9000, seen);
    for (cnt = 0; cnt < WAIT_LIMIT; cnt++) begin
      @(posedge clk_i);
      if (refill_req_valid_o && refill_req_id_o == ID_PREFETCH) break;
    end
    if (cnt == WAIT_LIMIT) begin
      timeouts++;
      $display("No prefetch request followed the hit on 9000");
    end else begin
      assert (refill_req_addr_o == 32'h9010) else begin
        errors++;
        $display("FAILED refill_req_addr_o %h expected %h", refill_req_addr_o, 32'h9010);
      end
    end

    random_fetches(40);
    repeat (10) @(posedge clk_i);

    $display("Errors: %0d checks, %0d timeouts, %0d assertions",
             errors, timeouts, dut.i_checker.fail_count);
    if (errors == 0 && timeouts == 0 && dut.i_checker.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
